// ==== dv/dmix_tb.sv ====
`timescale 1ns/1ps

module dmix_tb;

    localparam int NUM_CH = 2;
    // frames per test that also size the watchdog
    localparam int F_PASS = 8;
    localparam int F_MIX  = 10;
    localparam int F_SAT  = 8;
    localparam int F_OVF  = 8;
    localparam int F_RST  = 3;
    localparam int F_HOLD = 8;
    localparam int TOTAL_FRAMES = F_PASS + F_MIX + F_SAT + F_OVF + F_RST + F_HOLD;
    localparam longint TIMEOUT_NS = longint'(TOTAL_FRAMES) * 128 * 20 * 11 / 10;

    // stimulus modes
    localparam int M_NONE  = 0;  // no writes
    localparam int M_PAIR  = 1;  // one write per side per input per frame
    localparam int M_LEFT  = 2;  // input 0 left only
    localparam int M_BURST = 3;  // six writes to input 0 left in one frame

    logic                           clk245760;
    logic                           rst_n;
    logic [NUM_CH-1:0]              in_wr;
    logic [NUM_CH-1:0]              in_lr;
    dmix_pkg::sample_t [NUM_CH-1:0] in_data;
    dmix_pkg::vol_t [NUM_CH*2-1:0]  vol;
    logic                           dac_sck;
    logic                           dac_bck;
    logic                           dac_lrck;
    logic                           dac_data;

    integer seed;

    // reference fifos with the oldest entry at index 0
    dmix_pkg::sample_t mq [NUM_CH][2][4];
    int                mcnt [NUM_CH][2];
    dmix_pkg::sample_t mhold [NUM_CH][2];
    dmix_pkg::sample_t prev_mix [2];   // mix popped at the last slot start of that side

    // i2s capture state
    bit                first;
    int                pos;            // frame position 0..127
    int                cyc;
    int                last_rise;      // cycle of the last lrck rise
    logic              prev_l;
    logic              prev_b;
    int                rises;          // bck rises since slot start
    logic [23:0]       cap;
    dmix_pkg::sample_t slot_exp;
    int                slot_side;

    int    mode;
    bit    sat_kind;                   // near full scale samples
    bit    rand_vol;
    int    burst_left;
    string test_name;
    int    test_err, test_chk, total_err, total_chk, tests_run, tests_failed;

    dmix_top #(
        .NUM_CH (NUM_CH)
    ) uut (
        .clk245760  (clk245760),
        .rst_n_i    (rst_n),
        .in_wr_i    (in_wr),
        .in_lr_i    (in_lr),
        .in_data_i  (in_data),
        .vol_i      (vol),
        .dac_sck_o  (dac_sck),
        .dac_bck_o  (dac_bck),
        .dac_lrck_o (dac_lrck),
        .dac_data_o (dac_data)
    );

    initial begin
        clk245760 = 1'b0;
        forever #10 clk245760 = ~clk245760;  // 20 ns
    end

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    task automatic report_error(string msg);
        test_err++;
        $display("%s: %s at frame position %0d", test_name, msg, pos);
    endtask

    task automatic check_value(string what, logic [23:0] exp, logic [23:0] act);
        test_chk++;
        if (exp !== act) begin
            test_err++;
            $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic model_reset();
        for (int c = 0; c < NUM_CH; c++) begin
            for (int s = 0; s < 2; s++) begin
                mcnt[c][s]  = 0;
                mhold[c][s] = '0;  // empty side repeats zero
            end
        end
        prev_mix[0] = '0;  // first frame is silence
        prev_mix[1] = '0;
    endtask

    function automatic dmix_pkg::sample_t model_pop(int ch, int side);
        if (mcnt[ch][side] > 0) begin
            mhold[ch][side] = mq[ch][side][0];
            for (int i = 0; i < 3; i++) begin
                mq[ch][side][i] = mq[ch][side][i+1];
            end
            mcnt[ch][side]--;
        end
        return mhold[ch][side];
    endfunction

    // saturated sum of (sample * vol) >>> 8 over all inputs
    function automatic dmix_pkg::sample_t model_mix(int side);
        longint            sum;
        longint            v;
        dmix_pkg::sample_t s;
        sum = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            s   = model_pop(c, side);
            v   = longint'(vol[2*c+side]);  // unsigned 8.8
            sum = sum + ((longint'(s) * v) >>> 8);
        end
        if (sum > 64'sd8388607) begin
            return 24'h7fffff;
        end else if (sum < -64'sd8388608) begin
            return 24'h800000;
        end
        return dmix_pkg::sample_t'(sum);
    endfunction

    task automatic start_slot(int side);
        slot_side      = side;
        rises          = 0;
        cap            = '0;
        slot_exp       = prev_mix[side];   // word popped one frame earlier
        prev_mix[side] = model_mix(side);  // dut pops this side now
    endtask

    function automatic dmix_pkg::sample_t new_sample(logic neg);
        int m;
        if (!sat_kind) begin
            return dmix_pkg::sample_t'($random(seed));
        end
        m = 32'h600000 + ($random(seed) & 32'h1fffff);  // close to full scale
        return neg ? dmix_pkg::sample_t'(-m) : dmix_pkg::sample_t'(m);
    endfunction

    task automatic write_input(int ch, int side, dmix_pkg::sample_t d);
        in_wr[ch]   = 1'b1;
        in_lr[ch]   = side[0];
        in_data[ch] = d;
        if (mcnt[ch][side] < 4) begin  // full side drops
            mq[ch][side][mcnt[ch][side]] = d;
            mcnt[ch][side]++;
        end
    endtask

    // writes only inside counts 16..40 and 80..104 clear of the pop sweeps
    task automatic drive_inputs();
        logic neg;
        in_wr = '0;
        case (mode)
            M_PAIR: begin
                if (pos == 20 || pos == 84) begin
                    neg = $random(seed);  // same sign on all inputs
                    for (int c = 0; c < NUM_CH; c++) begin
                        write_input(c, (pos == 84) ? 1 : 0, new_sample(neg));
                    end
                end
                if (rand_vol && pos == 30) begin
                    for (int i = 0; i < NUM_CH*2; i++) begin
                        vol[i] = dmix_pkg::vol_t'($random(seed));
                    end
                end
            end
            M_LEFT: if (pos == 20) write_input(0, 0, new_sample(1'b0));
            M_BURST: begin
                if (pos >= 16 && pos <= 26 && pos % 2 == 0 && burst_left > 0) begin
                    write_input(0, 0, new_sample(1'b0));
                    burst_left--;
                end
            end
            default: ;
        endcase
    endtask

    // sck follows the master clock, sampled in the middle of each phase
    task automatic check_sck();
        #5;
        if (dac_sck !== 1'b0) report_error("sck is not low while the clock is low");
        @(posedge clk245760);
        #5;
        if (dac_sck !== 1'b1) report_error("sck is not high while the clock is high");
    endtask

    // one clock with capture on the falling edge and then the drive
    task automatic cycle();
        check_sck();
        @(negedge clk245760);
        cyc++;
        if (first) begin
            first = 1'b0;
            pos   = 0;
            if (dac_lrck !== 1'b0 || dac_bck !== 1'b0 || dac_data !== 1'b0) begin
                report_error("dac outputs not low right after reset release");
            end
            start_slot(0);
        end else begin
            if (dac_bck === prev_b) report_error("bck did not toggle");
            if (dac_lrck && !prev_l) begin
                if (last_rise >= 0 && cyc - last_rise != 128) begin
                    report_error("lrck period is not 128 clocks");
                end
                last_rise = cyc;
                pos       = 64;
                start_slot(1);
            end else if (!dac_lrck && prev_l) begin
                pos = 0;
                start_slot(0);
            end else begin
                pos++;
                if (pos == 128) report_error("lrck did not change at the frame end");
            end
            if (dac_bck && !prev_b) begin
                rises++;
                if (rises == 1 && dac_data !== 1'b0) report_error("i2s delay bit is not zero");
                if (rises >= 2 && rises <= 25) cap = {cap[22:0], dac_data};  // msb first
                if (rises == 25) begin
                    check_value(slot_side ? "right slot" : "left slot", slot_exp, cap);
                end
            end
        end
        prev_l = dac_lrck;
        prev_b = dac_bck;
        drive_inputs();
    endtask

    task automatic run_frames(int n);
        repeat (n * 128) cycle();
    endtask

    task automatic do_reset();
        @(negedge clk245760);
        rst_n = 1'b0;
        in_wr = '0;
        model_reset();
        repeat (2) begin
            @(negedge clk245760);
            if (dac_lrck !== 1'b0 || dac_bck !== 1'b0 || dac_data !== 1'b0) begin
                report_error("dac outputs not low during reset");
            end
        end
        rst_n     = 1'b1;
        first     = 1'b1;  // next falling edge is count 0
        last_rise = -1;
    endtask

    task automatic begin_test(string name);
        test_name = name;
        test_err  = 0;
        test_chk  = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_err += test_err;
        total_chk += test_chk;
        if (test_err == 0) begin
            $display("%-12s pass, %0d slot checks", test_name, test_chk);
        end else begin
            tests_failed++;
            $display("%-12s fail, %0d errors in %0d slot checks", test_name, test_err, test_chk);
        end
    endtask

    initial begin
        seed       = 32'hce7e4817;
        rst_n      = 1'b0;
        in_wr      = '0;
        in_lr      = '0;
        in_data    = '0;
        vol        = '0;
        mode       = M_NONE;
        sat_kind   = 1'b0;
        rand_vol   = 1'b0;
        burst_left = 0;
        first      = 1'b1;
        cyc        = 0;
        pos        = 0;
        last_rise  = -1;
        prev_l     = 1'b0;
        prev_b     = 1'b0;
        total_err  = 0;
        total_chk  = 0;
        tests_run  = 0;
        tests_failed = 0;

        begin_test("passthrough");
        vol = {16'h0000, 16'h0000, 16'h0100, 16'h0100};  // input 0 at unity with input 1 muted
        do_reset();
        mode = M_PAIR;
        run_frames(F_PASS);
        end_test();

        begin_test("mixing");
        rand_vol = 1'b1;
        for (int i = 0; i < NUM_CH*2; i++) vol[i] = dmix_pkg::vol_t'($random(seed));
        run_frames(F_MIX);
        end_test();

        begin_test("saturation");
        rand_vol = 1'b0;
        sat_kind = 1'b1;
        for (int i = 0; i < NUM_CH*2; i++) begin
            vol[i] = 16'h0180 + dmix_pkg::vol_t'($random(seed) & 32'hff);  // above unity
        end
        run_frames(F_SAT);
        end_test();

        begin_test("overflow");
        sat_kind = 1'b0;
        vol      = {16'h0000, 16'h0000, 16'h0100, 16'h0100};
        mode     = M_NONE;
        run_frames(2);  // drain the fifos
        burst_left = 6;
        mode       = M_BURST;
        run_frames(F_OVF - 2);
        end_test();

        begin_test("reset");
        mode = M_PAIR;
        do_reset();
        run_frames(F_RST);
        end_test();

        begin_test("underflow");
        do_reset();  // right side never written after this
        mode = M_LEFT;
        run_frames(2);
        mode = M_NONE;
        run_frames(F_HOLD - 2);
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_chk, total_err);
        if (total_err == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module dmix_tb \
    --Mdir obj_dir -o dmix_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/dmix_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// ==== sim.f ====
source/dmix_pkg.sv
source/sample_fifo.sv
source/mixer.sv
source/dac_drv.sv
source/dmix_top.sv
dv/dmix_tb.sv

// ==== source/dac_drv.sv ====
`timescale 1ns/1ps

module dac_drv (
    input  logic              clk245760,
    input  logic              rst_n_i,
    // pop/ack toward the mixer
    output logic [1:0]        pop_o,   // bit 0 left, bit 1 right
    input  logic [1:0]        ack_i,
    input  dmix_pkg::sample_t data_i,
    // i2s pins
    output logic              sck_o,
    output logic              bck_o,
    output logic              lrck_o,
    output logic              data_o
);

    localparam int CNT_W     = $clog2(dmix_pkg::FRAME_CLKS);
    localparam int SLOT_CLKS = dmix_pkg::FRAME_CLKS / 2;
    // trailing zeros of the word less the i2s delay bit
    localparam int PAD_W     = dmix_pkg::BITS_PER_SIDE - dmix_pkg::SAMPLE_W - 1;

    dmix_pkg::dac_state_e                state;
    logic [CNT_W-1:0]                    cnt;      // 0..127 within the frame
    dmix_pkg::sample_t                   word_l;   // next left slot
    dmix_pkg::sample_t                   word_r;   // next right slot
    logic [dmix_pkg::BITS_PER_SIDE-1:0]  shreg;    // msb is on the pin

    assign sck_o  = clk245760;              // master clock to the dac
    assign bck_o  = cnt[0];                 // clk/2 rising on odd counts
    assign lrck_o = (state == dmix_pkg::DAC_RIGHT);
    assign data_o = shreg[dmix_pkg::BITS_PER_SIDE-1];

    always_ff @(posedge clk245760 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state  <= dmix_pkg::DAC_IDLE;
            cnt    <= '0;
            pop_o  <= '0;
            word_l <= '0;  // first frame plays silence
            word_r <= '0;
            shreg  <= '0;
        end else begin
            pop_o <= '0;

            // acked words wait here until their slot comes round again
            if (ack_i[0]) begin
                word_l <= data_i;
            end
            if (ack_i[1]) begin
                word_r <= data_i;
            end

            case (state)
                dmix_pkg::DAC_IDLE: begin
                    // count stays at 0 and the first left slot starts next cycle
                    state    <= dmix_pkg::DAC_LEFT;
                    pop_o[0] <= 1'b1;
                    shreg    <= {1'b0, word_l, {PAD_W{1'b0}}};
                end
                default: begin
                    cnt <= cnt + 1'b1;  // wraps at frame end
                    if (cnt == CNT_W'(dmix_pkg::FRAME_CLKS-1)) begin
                        state    <= dmix_pkg::DAC_LEFT;
                        pop_o[0] <= 1'b1;                               // left pop at 0
                        shreg    <= {1'b0, word_l, {PAD_W{1'b0}}};
                    end else if (cnt == CNT_W'(SLOT_CLKS-1)) begin
                        state    <= dmix_pkg::DAC_RIGHT;
                        pop_o[1] <= 1'b1;                               // right pop at 64
                        shreg    <= {1'b0, word_r, {PAD_W{1'b0}}};
                    end else if (cnt[0]) begin
                        // bck falls so the next bit goes onto the pin
                        shreg <= {shreg[dmix_pkg::BITS_PER_SIDE-2:0], 1'b0};
                    end
                end
            endcase
        end
    end

endmodule

// ==== source/dmix_pkg.sv ====
package dmix_pkg;

    // sample format
    localparam int SAMPLE_W = 24;  // pcm bits per sample

    // frame layout on the dac side
    localparam int FRAME_CLKS    = 128;  // clk245760 cycles per stereo frame, 192k
    localparam int BITS_PER_SIDE = 32;   // bck periods per lrck half

    // signed pcm, two's complement
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // 8.8 fixed point gain
    // 16'h0100 is unity
    typedef logic [15:0] vol_t;

    // mix accumulator
    // 24b x 17b product is 41b, >>>8 leaves 33b, 8 of those still fit
    typedef logic signed [41:0] acc_t;

    // i2s generator states
    typedef enum logic [1:0] {
        DAC_IDLE,   // out of reset, waiting for first frame
        DAC_LEFT,   // lrck low half
        DAC_RIGHT   // lrck high half
    } dac_state_e;

endpackage

// ==== source/dmix_top.sv ====
`timescale 1ns/1ps

module dmix_top #(
    parameter int NUM_CH = 2  // stereo inputs, 1..8
)(
    input  logic                           clk245760,
    input  logic                           rst_n_i,
    // decoded input samples, one strobe per input
    input  logic [NUM_CH-1:0]              in_wr_i,
    input  logic [NUM_CH-1:0]              in_lr_i,     // 0 left, 1 right
    input  dmix_pkg::sample_t [NUM_CH-1:0] in_data_i,
    input  dmix_pkg::vol_t [NUM_CH*2-1:0]  vol_i,       // left at the lower index
    // i2s to the dac
    output logic                           dac_sck_o,
    output logic                           dac_bck_o,
    output logic                           dac_lrck_o,
    output logic                           dac_data_o
);

    logic [NUM_CH*2-1:0]              src_pop;   // mixer to fifos
    logic [NUM_CH*2-1:0]              src_ack;
    dmix_pkg::sample_t [NUM_CH-1:0]   src_data;
    logic [1:0]                       mix_pop;   // dac to mixer
    logic [1:0]                       mix_ack;
    dmix_pkg::sample_t                mix_data;

    // one stereo buffer per input
    for (genvar i = 0; i < NUM_CH; i++) begin : g_in
        sample_fifo u_fifo (
            .clk245760 (clk245760),
            .rst_n_i   (rst_n_i),
            .wr_i      (in_wr_i[i]),
            .lr_i      (in_lr_i[i]),
            .data_i    (in_data_i[i]),
            .pop_i     (src_pop[2*i +: 2]),
            .ack_o     (src_ack[2*i +: 2]),
            .data_o    (src_data[i])
        );
    end

    mixer #(
        .NUM_CH (NUM_CH)
    ) u_mixer (
        .clk245760  (clk245760),
        .rst_n_i    (rst_n_i),
        .src_pop_o  (src_pop),
        .src_ack_i  (src_ack),
        .src_data_i (src_data),
        .vol_i      (vol_i),
        .pop_i      (mix_pop),
        .ack_o      (mix_ack),
        .data_o     (mix_data)
    );

    dac_drv u_dac_drv (
        .clk245760 (clk245760),
        .rst_n_i   (rst_n_i),
        .pop_o     (mix_pop),
        .ack_i     (mix_ack),
        .data_i    (mix_data),
        .sck_o     (dac_sck_o),
        .bck_o     (dac_bck_o),
        .lrck_o    (dac_lrck_o),
        .data_o    (dac_data_o)
    );

endmodule

// ==== source/mixer.sv ====
`timescale 1ns/1ps

module mixer #(
    parameter int NUM_CH = 2
)(
    input  logic                             clk245760,
    input  logic                             rst_n_i,
    // toward the input fifos, two bits per channel
    output logic [NUM_CH*2-1:0]              src_pop_o,
    input  logic [NUM_CH*2-1:0]              src_ack_i,
    input  dmix_pkg::sample_t [NUM_CH-1:0]   src_data_i,
    // gains, {right, left} per channel
    input  dmix_pkg::vol_t [NUM_CH*2-1:0]    vol_i,
    // toward the dac driver
    input  logic [1:0]                       pop_i,
    output logic [1:0]                       ack_o,
    output dmix_pkg::sample_t                data_o
);

    localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

    // clamp limits of a 24 bit sample
    localparam dmix_pkg::acc_t SAT_HI = dmix_pkg::acc_t'(2**(dmix_pkg::SAMPLE_W-1) - 1);
    localparam dmix_pkg::acc_t SAT_LO = -dmix_pkg::acc_t'(2**(dmix_pkg::SAMPLE_W-1));

    typedef enum logic [1:0] {
        MIX_IDLE,   // waiting for a pop from the dac
        MIX_WAIT,   // source pop out, waiting for its ack
        MIX_DONE    // sum complete, clamp and ack
    } mix_state_e;

    mix_state_e         state;
    logic               side;        // 0 left, 1 right
    logic [CH_W-1:0]    ch;          // channel being popped
    logic [CH_W-1:0]    ch_nxt;
    logic [CH_W:0]      sel;         // {ch, side}, index into pop/ack/vol
    logic               last_ch;
    logic               src_ack;
    dmix_pkg::sample_t  cur_sample;
    dmix_pkg::vol_t     cur_vol;
    logic signed [40:0] prod;        // 24b signed x 17b signed
    dmix_pkg::acc_t     term;
    dmix_pkg::acc_t     acc;

    assign ch_nxt  = ch + 1'b1;
    assign sel     = {ch, side};
    assign last_ch = (ch == CH_W'(NUM_CH-1));
    assign src_ack = src_ack_i[sel];

    // scale the sample currently on the source bus
    always_comb begin
        cur_sample = src_data_i[ch];
        cur_vol    = vol_i[sel];
        prod       = cur_sample * $signed({1'b0, cur_vol});  // vol is unsigned
        term       = dmix_pkg::acc_t'(prod >>> 8);           // drop 8.8 fraction
    end

    // sweep control
    always_ff @(posedge clk245760 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= MIX_IDLE;
            side      <= 1'b0;
            ch        <= '0;
            src_pop_o <= '0;
            ack_o     <= '0;
        end else begin
            src_pop_o <= '0;  // pops are single pulses
            ack_o     <= '0;
            case (state)
                MIX_IDLE: begin
                    if (|pop_i) begin
                        side  <= pop_i[1];
                        ch    <= '0;
                        src_pop_o[{{CH_W{1'b0}}, pop_i[1]}] <= 1'b1;  // channel 0 first
                        state <= MIX_WAIT;
                    end
                end
                MIX_WAIT: begin
                    if (src_ack) begin
                        if (last_ch) begin
                            state <= MIX_DONE;
                        end else begin
                            ch <= ch_nxt;
                            src_pop_o[{ch_nxt, side}] <= 1'b1;  // next channel, same side
                        end
                    end
                end
                MIX_DONE: begin
                    ack_o[side] <= 1'b1;  // 2*NUM_CH+2 after the dac pop
                    state       <= MIX_IDLE;
                end
                default: state <= MIX_IDLE;
            endcase
        end
    end

    // accumulate and clamp
    always_ff @(posedge clk245760) begin
        if (state == MIX_IDLE && |pop_i) begin
            acc <= '0;
        end else if (state == MIX_WAIT && src_ack) begin
            acc <= acc + term;
        end
        if (state == MIX_DONE) begin
            if (acc > SAT_HI) begin
                data_o <= dmix_pkg::sample_t'(SAT_HI);
            end else if (acc < SAT_LO) begin
                data_o <= dmix_pkg::sample_t'(SAT_LO);
            end else begin
                data_o <= dmix_pkg::sample_t'(acc);  // in range, low bits exact
            end
        end
    end

endmodule

// ==== source/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo (
    input  logic              clk245760,
    input  logic              rst_n_i,
    // write side, already decoded samples
    input  logic              wr_i,
    input  logic              lr_i,       // 0 left, 1 right
    input  dmix_pkg::sample_t data_i,
    // pop/ack toward the mixer
    input  logic [1:0]        pop_i,      // bit 0 left, bit 1 right
    output logic [1:0]        ack_o,
    output dmix_pkg::sample_t data_o
);

    localparam int DEPTH = 4;

    dmix_pkg::sample_t mem [2][DEPTH];   // [side][entry]
    logic [1:0]        wr_ptr [2];
    logic [1:0]        rd_ptr [2];
    logic [2:0]        cnt [2];          // occupancy 0..4
    dmix_pkg::sample_t hold [2];         // last popped value per side
    logic [1:0]        wr_en;            // write accepted on that side
    logic [1:0]        rd_en;            // pop takes a real entry

    // full side drops, empty side falls back to hold
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            wr_en[s] = wr_i && (lr_i == s[0]) && (cnt[s] != 3'(DEPTH));
            rd_en[s] = pop_i[s] && (cnt[s] != 3'd0);
        end
    end

    always_ff @(posedge clk245760 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o <= '0;
            for (int s = 0; s < 2; s++) begin
                wr_ptr[s] <= '0;
                rd_ptr[s] <= '0;
                cnt[s]    <= '0;
                hold[s]   <= '0;  // empty side repeats zero until written
            end
        end else begin
            ack_o <= pop_i;  // always one cycle after pop
            for (int s = 0; s < 2; s++) begin
                if (wr_en[s]) begin
                    wr_ptr[s] <= wr_ptr[s] + 2'd1;  // wraps at 4
                end
                if (rd_en[s]) begin
                    rd_ptr[s] <= rd_ptr[s] + 2'd1;
                    hold[s]   <= mem[s][rd_ptr[s]];
                end
                case ({wr_en[s], rd_en[s]})
                    2'b10:   cnt[s] <= cnt[s] + 3'd1;
                    2'b01:   cnt[s] <= cnt[s] - 3'd1;
                    default: ;  // both or neither, level unchanged
                endcase
            end
        end
    end

    // storage and read data
    always_ff @(posedge clk245760) begin
        for (int s = 0; s < 2; s++) begin
            if (wr_en[s]) begin
                mem[s][wr_ptr[s]] <= data_i;
            end
        end
        // only one side is popped at a time on this link
        if (pop_i[1]) begin
            data_o <= rd_en[1] ? mem[1][rd_ptr[1]] : hold[1];
        end else if (pop_i[0]) begin
            data_o <= rd_en[0] ? mem[0][rd_ptr[0]] : hold[0];
        end
    end

endmodule
